/* hw/bpu_settings.svh */
`ifndef BPU_SETTINGS_SVH
`define BPU_SETTINGS_SVH

// datapath
`define XLEN          32
`define HIST_LEN      16            // global history bits

// direction predictor tables
`define BIM_ENTRIES   512
`define TAG_ENTRIES   256           // per tagged table
`define TAG_BITS      10
`define PTAG_BITS     6             // upper tag bits used for the match

// target prediction
`define BTB_ENTRIES   256
`define BTB_TAG_BITS  14
`define RAS_DEPTH     8

// rv32 control-flow opcodes
`define OP_BRANCH     7'b1100011
`define OP_JAL        7'b1101111
`define OP_JALR       7'b1100111

`endif

/* hw/bpu_pkg.sv */
`include "bpu_settings.svh"

package bpu_pkg;

    // B-type view, also gives rs1 for return detection
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // J-type view, rd sits at the same bits in I-type jalr
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef enum logic [1:0] {
        PROV_BIM = 2'd0,
        PROV_T0  = 2'd1,
        PROV_T1  = 2'd2
    } provider_e;

    typedef logic [1:0] ctr2_t;

    function automatic logic is_branch(inst_u i);
        return i.b_fmt.opcode == `OP_BRANCH;
    endfunction

    function automatic logic is_jal(inst_u i);
        return i.j_fmt.opcode == `OP_JAL;
    endfunction

    function automatic logic is_jalr(inst_u i);
        return i.j_fmt.opcode == `OP_JALR;
    endfunction

    // link register written
    function automatic logic is_call(inst_u i);
        return (is_jal(i) || is_jalr(i)) && (i.j_fmt.rd != 5'd0);
    endfunction

    // jalr x0, 0(ra)
    function automatic logic is_ret(inst_u i);
        return is_jalr(i) && (i.j_fmt.rd == 5'd0) && (i.b_fmt.rs1 == 5'd1);
    endfunction

    function automatic logic [`XLEN-1:0] b_offset(inst_u i);
        return {{(`XLEN-13){i.b_fmt.imm12}}, i.b_fmt.imm12, i.b_fmt.imm11,
                i.b_fmt.imm10_5, i.b_fmt.imm4_1, 1'b0};
    endfunction

    function automatic logic [`XLEN-1:0] j_offset(inst_u i);
        return {{(`XLEN-21){i.j_fmt.imm20}}, i.j_fmt.imm20, i.j_fmt.imm19_12,
                i.j_fmt.imm11, i.j_fmt.imm10_1, 1'b0};
    endfunction

    // saturating step
    function automatic ctr2_t ctr_next(ctr2_t c, logic taken);
        if (taken) begin
            return (c == 2'b11) ? c : c + 2'b01;
        end
        return (c == 2'b00) ? c : c - 2'b01;
    endfunction

endpackage

/* hw/bpu_train_if.sv */
`include "bpu_settings.svh"

// execute-stage resolution of one control-flow instruction
interface bpu_train_if;

    logic                 valid;      // one-cycle strobe, never stalled
    logic                 taken;      // actual outcome
    logic                 correct;    // fetch prediction matched
    logic [`XLEN-1:0]     pc;
    logic [`HIST_LEN-1:0] history;    // history seen at fetch
    logic [`XLEN-1:0]     target;     // resolved target
    logic [`XLEN-1:0]     inst;

    modport src (
        output valid, taken, correct, pc, history, target, inst
    );

    modport sink (
        input valid, taken, correct, pc, history, target, inst
    );

endinterface

/* hw/bpu_dir_pred.sv */
`include "bpu_settings.svh"

module bpu_dir_pred
    import bpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`XLEN-1:0]     pc_i,
    bpu_train_if.sink            trn,
    output logic                 taken_o,
    output logic [`HIST_LEN-1:0] history_o
);

    localparam int BIM_IW = $clog2(`BIM_ENTRIES);
    localparam int TAG_IW = $clog2(`TAG_ENTRIES);

    ctr2_t                bim_ctr [`BIM_ENTRIES];
    ctr2_t                t0_ctr  [`TAG_ENTRIES];
    ctr2_t                t1_ctr  [`TAG_ENTRIES];
    logic [`TAG_BITS-1:0] t0_tag  [`TAG_ENTRIES];
    logic [`TAG_BITS-1:0] t1_tag  [`TAG_ENTRIES];
    logic [`HIST_LEN-1:0] ghist;

    // fetch side lookup
    logic [BIM_IW-1:0]    f_bim_idx;
    logic [TAG_IW-1:0]    f_t0_idx;
    logic [TAG_IW-1:0]    f_t1_idx;
    provider_e            f_prov;

    // execute side, recomputed from the trained pc and history
    logic [BIM_IW-1:0]    u_bim_idx;
    logic [TAG_IW-1:0]    u_t0_idx;
    logic [TAG_IW-1:0]    u_t1_idx;
    provider_e            u_prov;

    // sel 0 folds low history into T0, sel 1 folds high history into T1
    function automatic logic [TAG_IW-1:0] tbl_index(logic sel, logic [`XLEN-1:0] pc,
                                                    logic [`HIST_LEN-1:0] h);
        return pc[TAG_IW-1:0] ^ (sel ? h[2*TAG_IW-1:TAG_IW] : h[TAG_IW-1:0]);
    endfunction

    function automatic logic [`TAG_BITS-1:0] tbl_tag(logic sel, logic [`XLEN-1:0] pc,
                                                     logic [`HIST_LEN-1:0] h);
        return pc[TAG_IW +: `TAG_BITS] ^
               (sel ? `TAG_BITS'(h[TAG_IW-1:0]) : h[`HIST_LEN-1 -: `TAG_BITS]);
    endfunction

    function automatic logic ptag_eq(logic [`TAG_BITS-1:0] a, logic [`TAG_BITS-1:0] b);
        return a[`TAG_BITS-1 -: `PTAG_BITS] == b[`TAG_BITS-1 -: `PTAG_BITS];
    endfunction

    // longest matching history wins
    function automatic provider_e pick(logic t0_hit, logic t1_hit);
        if (t1_hit) begin
            return PROV_T1;
        end
        return t0_hit ? PROV_T0 : PROV_BIM;
    endfunction

    // tagged counters jump to the outcome on a mispredict
    function automatic ctr2_t ctr_train(ctr2_t c, logic correct, logic taken);
        return correct ? ctr_next(c, taken) : {2{taken}};
    endfunction

    assign f_bim_idx = pc_i[BIM_IW:1];
    assign f_t0_idx  = tbl_index(1'b0, pc_i, ghist);
    assign f_t1_idx  = tbl_index(1'b1, pc_i, ghist);
    assign f_prov    = pick(ptag_eq(t0_tag[f_t0_idx], tbl_tag(1'b0, pc_i, ghist)),
                            ptag_eq(t1_tag[f_t1_idx], tbl_tag(1'b1, pc_i, ghist)));

    assign u_bim_idx = trn.pc[BIM_IW:1];
    assign u_t0_idx  = tbl_index(1'b0, trn.pc, trn.history);
    assign u_t1_idx  = tbl_index(1'b1, trn.pc, trn.history);
    assign u_prov    = pick(ptag_eq(t0_tag[u_t0_idx], tbl_tag(1'b0, trn.pc, trn.history)),
                            ptag_eq(t1_tag[u_t1_idx], tbl_tag(1'b1, trn.pc, trn.history)));

    always_comb begin
        case (f_prov)
            PROV_T1: taken_o = t1_ctr[f_t1_idx][1];
            PROV_T0: taken_o = t0_ctr[f_t0_idx][1];
            default: taken_o = bim_ctr[f_bim_idx][1];
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
            for (int i = 0; i < `BIM_ENTRIES; i++) begin
                bim_ctr[i] <= 2'b01;                // weakly not-taken
            end
            for (int i = 0; i < `TAG_ENTRIES; i++) begin
                t0_ctr[i] <= 2'b01;
                t1_ctr[i] <= 2'b01;
                t0_tag[i] <= '0;
                t1_tag[i] <= '0;
            end
        end else if (trn.valid) begin
            ghist <= {ghist[`HIST_LEN-2:0], trn.taken};
            bim_ctr[u_bim_idx] <= ctr_next(bim_ctr[u_bim_idx], trn.taken);
            case (u_prov)
                PROV_T1: t1_ctr[u_t1_idx] <= ctr_train(t1_ctr[u_t1_idx], trn.correct, trn.taken);
                PROV_T0: t0_ctr[u_t0_idx] <= ctr_train(t0_ctr[u_t0_idx], trn.correct, trn.taken);
                default: ;                          // bimodal already stepped
            endcase
        end
    end

    assign history_o = ghist;

    // both lookups must resolve to a legal table
    provider_legal: assert property (@(posedge clk) disable iff (rst)
        (f_prov inside {PROV_BIM, PROV_T0, PROV_T1}) &&
        (!trn.valid || (u_prov inside {PROV_BIM, PROV_T0, PROV_T1})))
        else $error("direction provider out of range");

endmodule

/* hw/bpu_btb.sv */
`include "bpu_settings.svh"

module bpu_btb
    import bpu_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [`XLEN-1:0] pc_i,
    bpu_train_if.sink        trn,
    output logic             hit_o,
    output logic [`XLEN-1:0] target_o
);

    localparam int IW = $clog2(`BTB_ENTRIES);

    logic [`BTB_TAG_BITS-1:0] tag_q [`BTB_ENTRIES];
    logic [`XLEN-1:0]         tgt_q [`BTB_ENTRIES];
    logic [`BTB_ENTRIES-1:0]  vld_q;

    logic [IW-1:0]            rd_idx;
    logic [IW-1:0]            wr_idx;
    logic                     wr_en;

    // word aligned index, tag from the top of the pc
    assign rd_idx   = pc_i[IW+1:2];
    assign hit_o    = vld_q[rd_idx] && (tag_q[rd_idx] == pc_i[`XLEN-1 -: `BTB_TAG_BITS]);
    assign target_o = tgt_q[rd_idx];

    assign wr_idx = trn.pc[IW+1:2];
    assign wr_en  = trn.valid && trn.taken &&
                    (is_branch(trn.inst) || is_jal(trn.inst) || is_jalr(trn.inst));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_q <= '0;
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                tag_q[i] <= '0;
            end
        end else if (wr_en) begin
            vld_q[wr_idx] <= 1'b1;
            tag_q[wr_idx] <= trn.pc[`XLEN-1 -: `BTB_TAG_BITS];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tgt_q[wr_idx] <= trn.target;    // last taken target wins
        end
    end

endmodule

/* hw/bpu_ras.sv */
`include "bpu_settings.svh"

module bpu_ras
    import bpu_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             flush_i,
    bpu_train_if.sink        trn,
    output logic             valid_o,
    output logic [`XLEN-1:0] top_o
);

    localparam int AW = $clog2(`RAS_DEPTH);

    logic [`XLEN-1:0] stack_q [`RAS_DEPTH];
    logic [AW:0]      ptr_q;                // number of live entries
    logic [AW-1:0]    top_idx;
    logic [AW-1:0]    wr_idx;
    logic             upd;
    logic             full;
    logic             push;
    logic             pop;

    assign upd  = trn.valid && !flush_i;
    assign full = ptr_q == (AW+1)'(`RAS_DEPTH);
    assign push = upd && is_call(trn.inst);
    assign pop  = upd && is_ret(trn.inst) && (ptr_q != '0);

    // on overflow restart at the bottom
    assign wr_idx  = full ? '0 : ptr_q[AW-1:0];
    assign top_idx = AW'(ptr_q - 1'b1);

    assign valid_o = ptr_q != '0;
    assign top_o   = stack_q[top_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr_q <= '0;
        end else if (push) begin
            ptr_q <= full ? (AW+1)'(1) : ptr_q + 1'b1;
        end else if (pop) begin
            ptr_q <= ptr_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            stack_q[wr_idx] <= trn.pc + `XLEN'(4);  // return address
        end
    end

    ptr_in_range: assert property (@(posedge clk) disable iff (rst)
        ptr_q <= (AW+1)'(`RAS_DEPTH))
        else $error("RAS pointer past stack depth");

endmodule

/* hw/bpu_next_pc.sv */
`include "bpu_settings.svh"

module bpu_next_pc
    import bpu_pkg::*;
(
    input  logic [`XLEN-1:0] pc_i,
    input  inst_u            inst_i,
    input  logic             dir_taken_i,
    input  logic             btb_hit_i,
    input  logic [`XLEN-1:0] btb_target_i,
    input  logic             ras_valid_i,
    input  logic [`XLEN-1:0] ras_target_i,
    output logic             branch_o,
    output logic             taken_o,
    output logic [`XLEN-1:0] next_pc_o
);

    logic             taken;
    logic [`XLEN-1:0] target;
    logic [`XLEN-1:0] seq_pc;

    assign seq_pc = pc_i + `XLEN'(4);

    assign branch_o = is_branch(inst_i) || is_jal(inst_i) || is_jalr(inst_i);

    always_comb begin
        taken  = 1'b0;
        target = btb_target_i;
        if (is_ret(inst_i)) begin
            // stack first, btb as fallback
            taken  = ras_valid_i || btb_hit_i;
            target = ras_valid_i ? ras_target_i : btb_target_i;
        end else if (is_jalr(inst_i)) begin
            taken = btb_hit_i;              // register target, btb only
        end else if (is_jal(inst_i)) begin
            taken = 1'b1;
            if (!btb_hit_i) begin
                target = pc_i + j_offset(inst_i);
            end
        end else if (is_branch(inst_i)) begin
            taken = dir_taken_i;
            if (!btb_hit_i) begin
                target = pc_i + b_offset(inst_i);
            end
        end
    end

    assign taken_o   = taken;
    assign next_pc_o = taken ? target : seq_pc;

    // no combinational path outside control-flow decode may redirect fetch
    always_comb begin
        taken_needs_branch: assert (!taken_o || branch_o)
            else $error("taken prediction on a non control-flow instruction");
    end

endmodule

/* hw/bpu.sv */
`include "bpu_settings.svh"

module bpu (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush_i,

    // fetch
    input  logic [`XLEN-1:0]     if_pc_i,
    input  logic [`XLEN-1:0]     if_inst_i,

    // execute feedback
    input  logic                 train_valid_i,
    input  logic                 train_taken_i,
    input  logic                 train_correct_i,
    input  logic [`XLEN-1:0]     train_pc_i,
    input  logic [`HIST_LEN-1:0] train_history_i,
    input  logic [`XLEN-1:0]     train_target_i,
    input  logic [`XLEN-1:0]     train_inst_i,

    // prediction
    output logic                 branch_o,
    output logic                 pdt_taken_o,
    output logic [`XLEN-1:0]     pdt_pc_o,
    output logic [`HIST_LEN-1:0] history_o
);

    logic             dir_taken;
    logic             btb_hit;
    logic [`XLEN-1:0] btb_target;
    logic             ras_valid;
    logic [`XLEN-1:0] ras_target;

    bpu_train_if trn ();

    assign trn.valid   = train_valid_i;
    assign trn.taken   = train_taken_i;
    assign trn.correct = train_correct_i;
    assign trn.pc      = train_pc_i;
    assign trn.history = train_history_i;
    assign trn.target  = train_target_i;
    assign trn.inst    = train_inst_i;

    bpu_dir_pred u_dir (
        .clk(clk), .rst(rst), .pc_i(if_pc_i), .trn(trn),
        .taken_o(dir_taken), .history_o(history_o)
    );

    bpu_btb u_btb (
        .clk(clk), .rst(rst), .pc_i(if_pc_i), .trn(trn),
        .hit_o(btb_hit), .target_o(btb_target)
    );

    bpu_ras u_ras (
        .clk(clk), .rst(rst), .flush_i(flush_i), .trn(trn),
        .valid_o(ras_valid), .top_o(ras_target)
    );

    bpu_next_pc u_npc (
        .pc_i(if_pc_i), .inst_i(if_inst_i), .dir_taken_i(dir_taken),
        .btb_hit_i(btb_hit), .btb_target_i(btb_target),
        .ras_valid_i(ras_valid), .ras_target_i(ras_target),
        .branch_o(branch_o), .taken_o(pdt_taken_o), .next_pc_o(pdt_pc_o)
    );

endmodule

/* testbench/bpu_tb.sv */
`include "bpu_settings.svh"

module bpu_tb;

    localparam int PERIOD     = 10;
    localparam int RST_CYCLES = 4;
    localparam int STEPS      = 64;                   // upper bound on stimulus cycles
    localparam int TIMEOUT    = (RST_CYCLES + 2 * STEPS) * PERIOD;
    localparam logic [`XLEN-1:0] NOP = 32'h0000_0013;  // addi x0, x0, 0

    logic                 clk;
    logic                 rst;
    logic                 flush_i;
    logic [`XLEN-1:0]     if_pc_i;
    logic [`XLEN-1:0]     if_inst_i;
    logic                 train_valid_i;
    logic                 train_taken_i;
    logic                 train_correct_i;
    logic [`XLEN-1:0]     train_pc_i;
    logic [`HIST_LEN-1:0] train_history_i;
    logic [`XLEN-1:0]     train_target_i;
    logic [`XLEN-1:0]     train_inst_i;
    logic                 branch_o;
    logic                 pdt_taken_o;
    logic [`XLEN-1:0]     pdt_pc_o;
    logic [`HIST_LEN-1:0] history_o;

    // expectations for the lookup in flight
    logic                 chk_en;
    logic                 exp_branch;
    logic                 exp_taken;
    logic [`XLEN-1:0]     exp_pc;
    logic                 exp_sat;
    logic [`HIST_LEN-1:0] model_hist;       // history as of this cycle
    logic [`HIST_LEN-1:0] hist_next;        // after this cycle's training

    integer               seed;
    logic [7:0]           region;           // top pc byte, new one per pc
    int                   errors;
    int                   lookups;

    bpu dut_i (
        .clk(clk), .rst(rst), .flush_i(flush_i),
        .if_pc_i(if_pc_i), .if_inst_i(if_inst_i),
        .train_valid_i(train_valid_i), .train_taken_i(train_taken_i),
        .train_correct_i(train_correct_i), .train_pc_i(train_pc_i),
        .train_history_i(train_history_i), .train_target_i(train_target_i),
        .train_inst_i(train_inst_i),
        .branch_o(branch_o), .pdt_taken_o(pdt_taken_o), .pdt_pc_o(pdt_pc_o),
        .history_o(history_o)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT);
        $display("timeout: stimulus still running after %0d time units", TIMEOUT);
        $display("*** FAILED ***");
        $finish;
    end

    // rv32 encoders
    function automatic logic [`XLEN-1:0] enc_branch(logic [12:0] off);
        return {off[12], off[10:5], 5'd0, 5'd2, 3'b000, off[4:1], off[11], `OP_BRANCH};
    endfunction

    function automatic logic [`XLEN-1:0] enc_jal(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OP_JAL};
    endfunction

    function automatic logic [`XLEN-1:0] enc_jalr(logic [4:0] rd, logic [4:0] rs1);
        return {12'd0, rs1, 3'b000, rd, `OP_JALR};
    endfunction

    function automatic logic [`XLEN-1:0] sext13(logic [12:0] v);
        return {{(`XLEN-13){v[12]}}, v};
    endfunction

    function automatic logic [`XLEN-1:0] sext21(logic [20:0] v);
        return {{(`XLEN-21){v[20]}}, v};
    endfunction

    task automatic note_fail(input string what);
        $display("FAIL %0t: %s", $time, what);
        errors++;
    endtask

    task automatic new_pc(output logic [`XLEN-1:0] pc);
        logic [31:0] r;
        r      = $random(seed);
        pc     = {region, r[21:0], 2'b00};
        region = region + 8'd1;
    endtask

    task automatic next_cycle();
        @(negedge clk);
        model_hist = hist_next;
    endtask

    task automatic lookup(input logic [`XLEN-1:0] pc, input logic [`XLEN-1:0] inst,
                          input logic br, input logic tk, input logic [`XLEN-1:0] npc,
                          input logic sat);
        next_cycle();
        flush_i         = 1'b0;
        train_valid_i   = 1'b0;
        train_history_i = model_hist;
        if_pc_i         = pc;
        if_inst_i       = inst;
        exp_branch      = br;
        exp_taken       = tk;
        exp_pc          = npc;
        exp_sat         = sat;
        chk_en          = 1'b1;
        lookups++;
    endtask

    task automatic train(input logic [`XLEN-1:0] pc, input logic [`XLEN-1:0] inst,
                         input logic tk, input logic ok, input logic [`XLEN-1:0] tgt,
                         input logic flush);
        next_cycle();
        chk_en          = 1'b0;
        exp_sat         = 1'b0;
        flush_i         = flush;
        train_valid_i   = 1'b1;
        train_taken_i   = tk;
        train_correct_i = ok;
        train_pc_i      = pc;
        train_history_i = model_hist;
        train_target_i  = tgt;
        train_inst_i    = inst;
        hist_next       = {model_hist[`HIST_LEN-2:0], tk};
    endtask

    branch_ok: assert property (@(posedge clk) disable iff (rst)
        chk_en |-> (branch_o == exp_branch))
        else note_fail($sformatf("branch_o %0b expected %0b", $sampled(branch_o), exp_branch));

    taken_ok: assert property (@(posedge clk) disable iff (rst)
        chk_en |-> (pdt_taken_o == exp_taken))
        else note_fail($sformatf("pdt_taken_o %0b expected %0b", $sampled(pdt_taken_o),
                                 exp_taken));

    next_pc_ok: assert property (@(posedge clk) disable iff (rst)
        chk_en |-> (pdt_pc_o == exp_pc))
        else note_fail($sformatf("pdt_pc_o %h expected %h", $sampled(pdt_pc_o), exp_pc));

    history_ok: assert property (@(posedge clk) disable iff (rst)
        history_o == model_hist)
        else note_fail($sformatf("history_o %h expected %h", $sampled(history_o), model_hist));

    history_sat: assert property (@(posedge clk) disable iff (rst)
        exp_sat |-> (history_o == {`HIST_LEN{1'b1}}))
        else note_fail($sformatf("history_o %h not saturated", $sampled(history_o)));

    initial begin
        logic [`XLEN-1:0]     pc;
        logic [`XLEN-1:0]     alias_pc;
        logic [`XLEN-1:0]     tgt;
        logic [`XLEN-1:0]     inst;
        logic [`XLEN-1:0]     ret;
        logic [31:0]          r;
        logic [12:0]          boff;
        logic [20:0]          joff;
        logic [`HIST_LEN-1:0] h_look;

        seed = 52;
        region = 8'h10;
        errors = 0;
        lookups = 0;
        {chk_en, exp_branch, exp_taken, exp_sat} = '0;
        exp_pc = '0;
        model_hist = '0;
        hist_next = '0;
        flush_i = 1'b0;
        if_pc_i = '0;
        if_inst_i = NOP;
        {train_valid_i, train_taken_i, train_correct_i} = '0;
        train_pc_i = '0;
        train_history_i = '0;
        train_target_i = '0;
        train_inst_i = NOP;
        rst = 1'b1;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;

        // cold tables, nothing redirects
        new_pc(pc);
        lookup(pc, NOP, 1'b0, 1'b0, pc + 32'd4, 1'b0);
        new_pc(pc);
        r = $random(seed);
        lookup(pc, enc_branch({r[12:1], 1'b0}), 1'b1, 1'b0, pc + 32'd4, 1'b0);

        // jal without btb entry goes to its own offset
        new_pc(pc);
        r = $random(seed);
        joff = {r[20:1], 1'b0};
        lookup(pc, enc_jal(5'd0, joff), 1'b1, 1'b1, pc + sext21(joff), 1'b0);

        // branch made taken through an alias that shares the bimodal slot only
        new_pc(pc);
        r = $random(seed);
        boff = {r[12:1], 1'b0};
        inst = enc_branch(boff);
        h_look = {hist_next[`HIST_LEN-3:0], 2'b11};
        // tags stay zero, so keep both computed tags nonzero and let bimodal decide
        pc[17:12] = (h_look[15:10] == 6'h20) ? 6'h21 : 6'h20;
        alias_pc = pc ^ 32'h8000_0000;      // other btb tag
        repeat (2) train(alias_pc, inst, 1'b1, 1'b0, alias_pc + sext13(boff), 1'b0);
        lookup(pc, inst, 1'b1, 1'b1, pc + sext13(boff), 1'b0);

        // indirect jump learns its target from the btb
        new_pc(pc);
        new_pc(tgt);
        inst = enc_jalr(5'd0, 5'd5);
        lookup(pc, inst, 1'b1, 1'b0, pc + 32'd4, 1'b0);
        train(pc, inst, 1'b1, 1'b1, tgt, 1'b0);
        lookup(pc, inst, 1'b1, 1'b1, tgt, 1'b0);

        // saturate one branch
        new_pc(pc);
        new_pc(tgt);
        r = $random(seed);
        inst = enc_branch({r[12:1], 1'b0});
        repeat (20) train(pc, inst, 1'b1, 1'b1, tgt, 1'b0);
        lookup(pc, inst, 1'b1, 1'b1, tgt, 1'b1);

        // nested calls and returns
        ret = enc_jalr(5'd0, 5'd1);
        new_pc(alias_pc);
        train(alias_pc, enc_jal(5'd1, 21'd64), 1'b1, 1'b1, alias_pc + 32'd64, 1'b0);
        new_pc(pc);
        train(pc, enc_jal(5'd1, 21'd64), 1'b1, 1'b1, pc + 32'd64, 1'b0);
        new_pc(tgt);                        // return site
        lookup(tgt, ret, 1'b1, 1'b1, pc + 32'd4, 1'b0);
        train(tgt, ret, 1'b1, 1'b1, pc + 32'd4, 1'b0);
        lookup(tgt, ret, 1'b1, 1'b1, alias_pc + 32'd4, 1'b0);
        train(tgt, ret, 1'b1, 1'b1, alias_pc + 32'd4, 1'b0);

        // flushed call leaves the stack empty
        new_pc(pc);
        train(pc, enc_jal(5'd1, 21'd64), 1'b1, 1'b1, pc + 32'd64, 1'b1);
        new_pc(tgt);
        lookup(tgt, ret, 1'b1, 1'b0, tgt + 32'd4, 1'b0);

        // one call past the depth wraps to the bottom
        repeat (`RAS_DEPTH + 1) begin
            new_pc(pc);
            train(pc, enc_jal(5'd1, 21'd64), 1'b1, 1'b1, pc + 32'd64, 1'b0);
        end
        new_pc(tgt);
        lookup(tgt, ret, 1'b1, 1'b1, pc + 32'd4, 1'b0);

        next_cycle();
        chk_en = 1'b0;
        train_valid_i = 1'b0;
        @(negedge clk);
        $display("summary: %0d lookups, %0d errors", lookups, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* bpu.f */
+incdir+hw
hw/bpu_pkg.sv
hw/bpu_train_if.sv
hw/bpu_dir_pred.sv
hw/bpu_btb.sv
hw/bpu_ras.sv
hw/bpu_next_pc.sv
hw/bpu.sv
testbench/bpu_tb.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = bpu_tb
FLIST = bpu.f

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard hw/*.svh)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FLIST) $(SRCS) $(HDRS)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
